// File: include/soc_map.svh
`ifndef SOC_MAP_SVH
`define SOC_MAP_SVH

// Lowest address bit of the region selector
`define SOC_SEL_LSB 27

// Byte addresses at the bottom of each region
`define ROM_BASE   {soc_pkg::REGION_ROM,   {`SOC_SEL_LSB{1'b0}}}
`define RAM_BASE   {soc_pkg::REGION_RAM,   {`SOC_SEL_LSB{1'b0}}}
`define TIME_ADDR  {soc_pkg::REGION_TIME,  {`SOC_SEL_LSB{1'b0}}}
`define TIMER_ADDR {soc_pkg::REGION_TIMER, {`SOC_SEL_LSB{1'b0}}}
`define PORTS_ADDR {soc_pkg::REGION_PORTS, {`SOC_SEL_LSB{1'b0}}}

`endif

// File: hw/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // Data and address word of the memory bus
    typedef logic [31:0] word_t;

    // Byte-write mask, bit n enables byte lane n
    typedef logic [3:0] strobe_t;

    // Region selector from address bits 31 to 27
    typedef logic [4:0] region_t;

    localparam region_t REGION_ROM    = 5'h01; // Code memory
    localparam region_t REGION_RAM    = 5'h02; // Data memory
    localparam region_t REGION_TIME   = 5'h1B; // Free-running counter
    localparam region_t REGION_TIMER  = 5'h1C; // Interval timer period
    localparam region_t REGION_PORTS  = 5'h1F; // Buttons, LED and I2C lines

endpackage

`default_nettype wire

// File: hw/bus_if.sv
`default_nettype none

interface bus_if;
    import soc_pkg::*;

    word_t   addr;
    word_t   wdata;
    strobe_t wstrb;
    logic    write;
    logic    rom_sel;
    logic    ram_sel;
    logic    time_sel;
    logic    timer_sel;
    logic    ports_sel;

    modport master (
        output addr, wdata, wstrb, write,
        output rom_sel, ram_sel, time_sel, timer_sel, ports_sel
    );

    modport slave (
        input addr, wdata, wstrb, write,
        input rom_sel, ram_sel, time_sel, timer_sel, ports_sel
    );

endinterface

`default_nettype wire

// File: hw/bus_decoder.sv
`default_nettype none

`include "soc_map.svh"

module bus_decoder (
    input  logic              mem_valid,
    input  logic              nreset,
    input  logic              mem_req,
    input  soc_pkg::word_t    mem_addr,
    input  soc_pkg::word_t    mem_wdata,
    input  soc_pkg::strobe_t  mem_wstrb,
    input  soc_pkg::word_t    rom_rdata,
    input  soc_pkg::word_t    ram_rdata,
    input  soc_pkg::word_t    time_rdata,
    input  soc_pkg::word_t    ports_rdata,
    output logic              mem_ready,
    output soc_pkg::word_t    mem_rdata,
    bus_if.master             bus
);
    import soc_pkg::*;

    region_t region;
    region_t region_q; // Region of the request being answered
    logic    mapped;

    assign region = mem_addr[31:`SOC_SEL_LSB];
    assign mapped = region inside {REGION_ROM, REGION_RAM, REGION_TIME,
                                   REGION_TIMER, REGION_PORTS};

    assign bus.addr  = mem_addr;
    assign bus.wdata = mem_wdata;
    assign bus.wstrb = mem_wstrb;
    assign bus.write = |mem_wstrb; // Any strobe bit makes it a write

    assign bus.rom_sel   = mem_req && (region == REGION_ROM);
    assign bus.ram_sel   = mem_req && (region == REGION_RAM);
    assign bus.time_sel  = mem_req && (region == REGION_TIME);
    assign bus.timer_sel = mem_req && (region == REGION_TIMER);
    assign bus.ports_sel = mem_req && (region == REGION_PORTS);

    always_ff @(posedge mem_valid) begin
        if (!nreset) begin
            mem_ready <= 1'b0;
            region_q  <= '0;
        end else begin
            mem_ready <= mem_req && mapped; // Unmapped requests are never acknowledged
            if (mem_req) begin
                region_q <= region;
            end
        end
    end

    // The slaves registered their words at the request edge
    always_comb begin
        case (region_q)
            REGION_ROM:   mem_rdata = rom_rdata;
            REGION_RAM:   mem_rdata = ram_rdata;
            REGION_TIME:  mem_rdata = time_rdata;
            REGION_PORTS: mem_rdata = ports_rdata;
            default:      mem_rdata = '0; // Timer period is write only
        endcase
    end

endmodule

`default_nettype wire

// File: hw/byte_ram.sv
`default_nettype none

module byte_ram #(
    parameter int RAM_BITS = 11
) (
    input  logic            mem_valid,
    bus_if.slave            bus,
    output soc_pkg::word_t  rdata
);

    logic [3:0][7:0] mem [0:(1 << RAM_BITS) - 1]; // Four byte lanes per word
    logic [RAM_BITS - 1:0] word_addr;
    logic we;

    assign word_addr = bus.addr[RAM_BITS + 1:2];
    assign we = bus.ram_sel && bus.write;

    always_ff @(posedge mem_valid) begin
        if (bus.ram_sel) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (we && bus.wstrb[lane]) begin
                    mem[word_addr][lane] <= bus.wdata[8 * lane +: 8];
                end
            end
            rdata <= mem[word_addr]; // Old contents on a write
        end
    end

endmodule

`default_nettype wire

// File: hw/code_rom.sv
`default_nettype none

module code_rom #(
    parameter int ROM_BITS = 13
) (
    input  logic            mem_valid,
    bus_if.slave            bus,
    output soc_pkg::word_t  rdata
);
    import soc_pkg::*;

    word_t rom [0:(1 << ROM_BITS) - 1];

    initial begin
        $readmemh("code.hex", rom);
    end

    // Writes reach this region but never change the image
    always_ff @(posedge mem_valid) begin
        if (bus.rom_sel) begin
            rdata <= rom[bus.addr[ROM_BITS + 1:2]];
        end
    end

endmodule

`default_nettype wire

// File: hw/port_regs.sv
`default_nettype none

module port_regs (
    input  logic            mem_valid,
    input  logic            nreset,
    bus_if.slave            bus,
    input  logic [4:0]      buttons,
    input  logic            scl_in,
    input  logic            sda_in,
    output logic            led,
    output logic            scl,
    output logic            sda,
    output soc_pkg::word_t  rdata
);

    logic port_wr;
    logic port_rd;

    assign port_wr = bus.ports_sel && bus.write && bus.wstrb[0];
    assign port_rd = bus.ports_sel && !bus.write;

    always_ff @(posedge mem_valid) begin
        if (!nreset) begin
            led <= 1'b1;
            scl <= 1'b1; // I2C lines idle high
            sda <= 1'b1;
        end else if (port_wr) begin
            {led, scl, sda} <= bus.wdata[2:0];
        end
    end

    always_ff @(posedge mem_valid) begin
        if (port_rd) begin
            rdata <= {25'd0, buttons, scl_in, sda_in};
        end
    end

endmodule

`default_nettype wire

// File: hw/interval_timer.sv
`default_nettype none

module interval_timer (
    input  logic            mem_valid,
    input  logic            nreset,
    bus_if.slave            bus,
    input  logic            irq_clear,
    output logic            irq,
    output soc_pkg::word_t  time_rdata
);
    import soc_pkg::*;

    word_t time_count;
    word_t period;
    word_t countdown;
    logic  timer_wr;
    logic  expire;

    assign timer_wr = bus.timer_sel && bus.write;
    assign expire   = (countdown == 32'd1) && !timer_wr; // A new period overrides expiry

    always_ff @(posedge mem_valid) begin
        if (!nreset) begin
            time_count <= '0;
        end else begin
            time_count <= time_count + 32'd1;
        end
    end

    // Reads see the count before this edge's increment
    always_ff @(posedge mem_valid) begin
        if (bus.time_sel && !bus.write) begin
            time_rdata <= time_count;
        end
    end

    always_ff @(posedge mem_valid) begin
        if (!nreset) begin
            period    <= '0;
            countdown <= '0;
        end else if (timer_wr) begin
            period    <= bus.wdata;
            countdown <= bus.wdata; // Zero stops the timer
        end else if (expire) begin
            countdown <= period;
        end else if (countdown != '0) begin
            countdown <= countdown - 32'd1;
        end
    end

    always_ff @(posedge mem_valid) begin
        if (!nreset) begin
            irq <= 1'b0;
        end else if (irq_clear) begin
            irq <= 1'b0; // Clear wins over a rise in the same cycle
        end else if (expire) begin
            irq <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_subsystem.sv
`default_nettype none

module mem_subsystem #(
    parameter int RAM_BITS = 11,
    parameter int ROM_BITS = 13
) (
    input  logic              mem_valid,
    input  logic              nreset,
    input  logic              mem_req,
    input  soc_pkg::word_t    mem_addr,
    input  soc_pkg::word_t    mem_wdata,
    input  soc_pkg::strobe_t  mem_wstrb,
    output logic              mem_ready,
    output soc_pkg::word_t    mem_rdata,
    input  logic [4:0]        buttons,
    input  logic              scl_in,
    input  logic              sda_in,
    output logic              led,
    output logic              scl,
    output logic              sda,
    output logic              irq,
    input  logic              irq_clear
);
    import soc_pkg::*;

    word_t rom_rdata;
    word_t ram_rdata;
    word_t time_rdata;
    word_t ports_rdata;

    bus_if bus ();

    bus_decoder decoder0 (
        .mem_valid   (mem_valid),
        .nreset      (nreset),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .rom_rdata   (rom_rdata),
        .ram_rdata   (ram_rdata),
        .time_rdata  (time_rdata),
        .ports_rdata (ports_rdata),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata),
        .bus         (bus.master)
    );

    code_rom #(.ROM_BITS(ROM_BITS)) rom0 (
        .mem_valid (mem_valid),
        .bus       (bus.slave),
        .rdata     (rom_rdata)
    );

    byte_ram #(.RAM_BITS(RAM_BITS)) ram0 (
        .mem_valid (mem_valid),
        .bus       (bus.slave),
        .rdata     (ram_rdata)
    );

    port_regs ports0 (
        .mem_valid (mem_valid),
        .nreset    (nreset),
        .bus       (bus.slave),
        .buttons   (buttons),
        .scl_in    (scl_in),
        .sda_in    (sda_in),
        .led       (led),
        .scl       (scl),
        .sda       (sda),
        .rdata     (ports_rdata)
    );

    interval_timer timer0 (
        .mem_valid  (mem_valid),
        .nreset     (nreset),
        .bus        (bus.slave),
        .irq_clear  (irq_clear),
        .irq        (irq),
        .time_rdata (time_rdata)
    );

endmodule

`default_nettype wire

// File: test/tb_mem_subsystem.sv
`default_nettype none

`include "soc_map.svh"

module tb_mem_subsystem;
    timeunit 1ns;
    timeprecision 1ps;
    import soc_pkg::*;

    localparam int RAM_BITS = 11;
    localparam int ROM_BITS = 13;
    localparam int CLK_PERIOD = 100;
    localparam logic [15:0] SEED = 16'd39709;
    localparam int RAM_OPS = 96;
    localparam int ROM_OPS = 48;
    localparam int PORT_OPS = 48;
    localparam int TIME_OPS = 32;
    localparam int UNMAPPED_OPS = 32;
    localparam int TOTAL_REQS = 16 + RAM_OPS + 2 * ROM_OPS + PORT_OPS + TIME_OPS
                                + 2 * UNMAPPED_OPS;
    // Random gaps add at most two idle cycles per request
    localparam int TIMEOUT_NS = (3 * TOTAL_REQS + 256 + 100) * CLK_PERIOD;

    typedef logic [RAM_BITS - 1:0] ram_index_t;

    logic        mem_valid = 1'b0;
    logic        nreset;
    logic        mem_req;
    word_t       mem_addr;
    word_t       mem_wdata;
    strobe_t     mem_wstrb;
    logic        mem_ready;
    word_t       mem_rdata;
    logic [4:0]  buttons;
    logic        scl_in;
    logic        sda_in;
    logic        led;
    logic        scl;
    logic        sda;
    logic        irq;
    logic        irq_clear;

    word_t       rom_image [0:(1 << ROM_BITS) - 1];
    word_t       ram_model [0:(1 << RAM_BITS) - 1];
    ram_index_t  ram_pool [0:15]; // Word addresses that hold known data
    logic [2:0]  model_port;
    logic        model_irq;
    word_t       model_time;
    word_t       period;
    word_t       next_fire; // Cycle count at which the timer expires next
    logic        timer_on;
    logic        exp_ready;
    logic        exp_check;
    word_t       exp_rdata;
    string       exp_name;
    string       test_name;
    logic        checking;
    logic [15:0] lfsr;

    always #(CLK_PERIOD / 2) mem_valid = ~mem_valid;

    mem_subsystem #(.RAM_BITS(RAM_BITS), .ROM_BITS(ROM_BITS)) dut0 (
        .mem_valid (mem_valid),
        .nreset    (nreset),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .buttons   (buttons),
        .scl_in    (scl_in),
        .sda_in    (sda_in),
        .led       (led),
        .scl       (scl),
        .sda       (sda),
        .irq       (irq),
        .irq_clear (irq_clear)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    function automatic word_t rand_bits(input int count);
        word_t value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic word_t ram_address(input ram_index_t index);
        return `RAM_BASE | word_t'({index, 2'b00});
    endfunction

    function automatic word_t unmapped_address();
        region_t sel;
        sel = region_t'(rand_bits(5));
        while (sel inside {REGION_ROM, REGION_RAM, REGION_TIME, REGION_TIMER, REGION_PORTS}) begin
            sel = region_t'(rand_bits(5));
        end
        return {sel, 27'(rand_bits(27))};
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_port(input string name, input logic [2:0] expected,
                              input logic [2:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    // Called on a falling edge and returns on the next one
    task automatic drive_request(input word_t addr, input word_t wdata, input strobe_t wstrb);
        mem_req   = 1'b1;
        mem_addr  = addr;
        mem_wdata = wdata;
        mem_wstrb = wstrb;
        @(negedge mem_valid);
        mem_req   = 1'b0;
        mem_wstrb = '0;
    endtask

    task automatic idle_cycles(input int count);
        mem_req   = 1'b0;
        mem_wstrb = '0;
        repeat (count) @(negedge mem_valid);
    endtask

    task automatic random_gap();
        if (rand_bits(1) != 0) begin
            idle_cycles(1 + int'(rand_bits(1)));
        end
    endtask

    // Reference model, updated from the inputs seen at each request edge
    always @(posedge mem_valid) begin : reference_model
        region_t region;
        logic    is_write;
        logic    timer_write;
        logic    fire;
        region      = mem_addr[31:`SOC_SEL_LSB];
        is_write    = (mem_wstrb != '0);
        timer_write = mem_req && (region == REGION_TIMER) && is_write;
        exp_name    = test_name;
        exp_ready   = 1'b0;
        exp_check   = 1'b0;
        if (!nreset) begin
            model_time = '0;
            model_port = 3'b111;
            model_irq  = 1'b0;
            timer_on   = 1'b0;
            period     = '0;
            next_fire  = '0;
        end else begin
            fire = timer_on && (model_time == next_fire) && !timer_write;
            if (mem_req) begin
                exp_check = !is_write;
                case (region)
                    REGION_ROM: begin
                        exp_ready = 1'b1;
                        exp_rdata = rom_image[mem_addr[ROM_BITS + 1:2]];
                    end
                    REGION_RAM: begin
                        exp_ready = 1'b1;
                        exp_rdata = ram_model[mem_addr[RAM_BITS + 1:2]];
                        for (int lane = 0; lane < 4; lane++) begin
                            if (mem_wstrb[lane]) begin
                                ram_model[mem_addr[RAM_BITS + 1:2]][8 * lane +: 8] =
                                    mem_wdata[8 * lane +: 8];
                            end
                        end
                    end
                    REGION_TIME: begin
                        exp_ready = 1'b1;
                        exp_rdata = model_time;
                    end
                    REGION_TIMER: begin
                        exp_ready = 1'b1;
                        exp_check = 1'b0;
                        if (is_write) begin
                            period    = mem_wdata;
                            timer_on  = (mem_wdata != '0);
                            next_fire = model_time + mem_wdata;
                        end
                    end
                    REGION_PORTS: begin
                        exp_ready = 1'b1;
                        exp_rdata = {25'd0, buttons, scl_in, sda_in};
                        if (is_write && mem_wstrb[0]) begin
                            model_port = mem_wdata[2:0];
                        end
                    end
                    default: begin
                        exp_check = 1'b0;
                    end
                endcase
            end
            if (fire) begin
                next_fire = model_time + period;
            end
            if (irq_clear) begin
                model_irq = 1'b0;
            end else if (fire) begin
                model_irq = 1'b1;
            end
            model_time = model_time + 32'd1;
        end
    end

    always @(negedge mem_valid) begin : output_checker
        if (checking) begin
            check_bit($sformatf("%s ready", exp_name), exp_ready, mem_ready);
            if (exp_check) begin
                check_word($sformatf("%s rdata", exp_name), exp_rdata, mem_rdata);
            end
            check_port($sformatf("%s port outputs", exp_name), model_port, {led, scl, sda});
            check_bit($sformatf("%s irq", exp_name), model_irq, irq);
        end
    end

    task automatic exercise_ports();
        test_name = "ports";
        check_port("ports after reset", 3'b111, {led, scl, sda});
        for (int n = 0; n < PORT_OPS; n++) begin
            buttons = 5'(rand_bits(5));
            scl_in  = 1'(rand_bits(1));
            sda_in  = 1'(rand_bits(1));
            if (rand_bits(1) != 0) begin
                drive_request(`PORTS_ADDR, '0, '0);
            end else begin
                drive_request(`PORTS_ADDR, rand_bits(32), strobe_t'(rand_bits(4)));
            end
            random_gap();
        end
    endtask

    task automatic ram_byte_writes();
        strobe_t strobe;
        test_name = "ram";
        for (int n = 0; n < 16; n++) begin
            ram_pool[n] = ram_index_t'(rand_bits(RAM_BITS));
            drive_request(ram_address(ram_pool[n]), rand_bits(32), 4'hF);
        end
        for (int n = 0; n < RAM_OPS; n++) begin
            strobe = (rand_bits(1) != 0) ? strobe_t'(rand_bits(4)) : '0;
            drive_request(ram_address(ram_pool[int'(rand_bits(4))]), rand_bits(32), strobe);
            random_gap();
        end
    endtask

    task automatic rom_reads();
        word_t addr;
        test_name = "rom";
        for (int n = 0; n < ROM_OPS; n++) begin
            addr = `ROM_BASE | word_t'({4'(rand_bits(4)), 2'b00});
            if (rand_bits(2) == 0) begin
                drive_request(addr, rand_bits(32), 4'hF); // Acknowledged but ignored
            end
            drive_request(addr, '0, '0);
            random_gap();
        end
    endtask

    task automatic time_counter_reads();
        test_name = "time";
        for (int n = 0; n < TIME_OPS; n++) begin
            drive_request(`TIME_ADDR, '0, '0);
            random_gap();
        end
    endtask

    task automatic timer_interrupts();
        int p;
        test_name = "timer";
        p = 2 + int'(rand_bits(5));
        drive_request(`TIMER_ADDR, word_t'(p), 4'hF);
        idle_cycles(p - 1);
        check_bit("timer before first expiry", 1'b0, irq);
        idle_cycles(1);
        check_bit("timer first expiry", 1'b1, irq);
        irq_clear = 1'b1;
        idle_cycles(1);
        irq_clear = 1'b0;
        check_bit("timer after clear", 1'b0, irq);
        idle_cycles(p - 2);
        check_bit("timer before second expiry", 1'b0, irq);
        idle_cycles(1);
        check_bit("timer second expiry", 1'b1, irq);
        irq_clear = 1'b1; // Held across the third expiry
        idle_cycles(p);
        irq_clear = 1'b0;
        check_bit("timer clear against expiry", 1'b0, irq);
        drive_request(`TIMER_ADDR, '0, 4'hF);
        idle_cycles(3 * p);
        check_bit("timer stopped", 1'b0, irq);
    endtask

    task automatic unmapped_requests();
        test_name = "unmapped";
        for (int n = 0; n < UNMAPPED_OPS; n++) begin
            drive_request(unmapped_address(), rand_bits(32), strobe_t'(rand_bits(4)));
            drive_request(ram_address(ram_pool[int'(rand_bits(4))]), '0, '0);
        end
        idle_cycles(2);
    endtask

    initial begin : watchdog
        #(TIMEOUT_NS);
        abort_run("Watchdog expired before the tests finished");
    end

    initial begin
        nreset    = 1'b0;
        mem_req   = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        mem_wstrb = '0;
        buttons   = '0;
        scl_in    = 1'b1;
        sda_in    = 1'b1;
        irq_clear = 1'b0;
        checking  = 1'b0;
        test_name = "reset";
        lfsr      = SEED;
        $readmemh("code.hex", rom_image);
        repeat (5) @(negedge mem_valid);
        nreset   = 1'b1;
        checking = 1'b1;
        exercise_ports();
        ram_byte_writes();
        rom_reads();
        time_counter_reads();
        timer_interrupts();
        unmapped_requests();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: code.hex
// Code ROM image, one 32-bit word per line in hex
// First line is word address 0, later lines follow in order
10000117
ff010113
000010b7
00108093
08000293
0052a023
00100313
0062a223
0002a383
00138393
0072a023
fe000ae3
00000513
0ff00593
00b50633
0000006f
00008067
00000013

// File: filelist.f
+incdir+include
hw/soc_pkg.sv
hw/bus_if.sv
hw/bus_decoder.sv
hw/byte_ram.sv
hw/code_rom.sv
hw/port_regs.sv
hw/interval_timer.sv
hw/mem_subsystem.sv
test/tb_mem_subsystem.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_mem_subsystem \
    -f filelist.f \
    -Mdir obj_dir -o sim

output="$(./obj_dir/sim 2>&1 || true)"
echo "$output"

if grep -qx "Regression passed" <<< "$output"; then
    exit 0
else
    exit 1
fi
